// ==== design/upsample_config.svh ====
// ==================================================
// sizes for the feature-map upsampler
// include wherever a pixel, coordinate or address width is needed
// ==================================================
`ifndef UPSAMPLE_CONFIG_SVH
`define UPSAMPLE_CONFIG_SVH

// one single-channel pixel
`define UPS_PIXEL_W 8

// largest input frame is UPS_MAX_DIM x UPS_MAX_DIM
`define UPS_MAX_DIM 32

// holds a dimension 1 to 32, or an input coordinate
`define UPS_DIM_W 6

// output coordinate, up to 32 << 3
`define UPS_OUT_W 9

// frame buffer address over UPS_MAX_DIM * UPS_MAX_DIM
`define UPS_ADDR_W 10

// interpolation weight fraction, 256 is 1.0
`define UPS_FRAC_W 8

`endif

// ==== design/upsample_pkg.sv ====
// ==================================================
// types shared by the upsampler blocks
// referenced by scoped name, sizes come from the config header
// ==================================================
`include "upsample_config.svh"

package upsample_pkg;

    // ==================================================
    // plain vectors
    // ==================================================
    typedef logic [`UPS_PIXEL_W-1:0] pixel_t;
    typedef logic [`UPS_DIM_W-1:0]   dim_t;
    typedef logic [`UPS_OUT_W-1:0]   out_coord_t;
    typedef logic [`UPS_ADDR_W-1:0]  fb_addr_t;
    typedef logic [`UPS_FRAC_W-1:0]  frac_t;

    // log2 of the scale, 0..3 for 1x..8x
    typedef logic [1:0] scale_t;

    // ==================================================
    // grouped signals
    // ==================================================
    typedef struct packed {
        scale_t scale;
        logic   bilinear;
        dim_t   width;
        dim_t   height;
    } upsample_cfg_t;

    // four neighbours around one source position
    typedef struct packed {
        pixel_t tl;
        pixel_t tr;
        pixel_t bl;
        pixel_t br;
    } quad_t;

    typedef struct packed {
        dim_t  src_x;
        dim_t  src_y;
        frac_t frac_x;
        frac_t frac_y;
        logic  first;
        logic  eol;
    } sample_pos_t;

    // one output stream beat
    typedef struct packed {
        pixel_t pixel;
        logic   sof;
        logic   eol;
    } beat_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        FETCH,
        BLEND,
        EMIT
    } ups_state_t;

endpackage

// ==== design/upsample_fsm.sv ====
// ==================================================
// frame sequencing for the upsampler
// loads a frame, then fetches, blends and emits one output pixel at a time
// ==================================================
`timescale 1ns/1ps

module upsample_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid,
    input  logic in_sof,
    input  logic last_in,
    input  logic last_out,
    input  logic out_ready,
    output logic in_ready,
    output logic in_step,
    output logic wr_en,
    output logic rd_en,
    output logic blend_en,
    output logic out_step,
    output logic out_valid,
    output logic cfg_load
);

    upsample_pkg::ups_state_t state_q;
    upsample_pkg::ups_state_t state_d;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= upsample_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ==================================================
    // next state and strobes
    // ==================================================
    always_comb begin
        state_d   = state_q;
        in_ready  = 1'b0;
        in_step   = 1'b0;
        wr_en     = 1'b0;
        rd_en     = 1'b0;
        blend_en  = 1'b0;
        out_step  = 1'b0;
        out_valid = 1'b0;
        cfg_load  = 1'b0;
        case (state_q)
            upsample_pkg::IDLE: begin
                in_ready = 1'b1;
                // beats without sof are taken and dropped here
                if (in_valid && in_sof) begin
                    cfg_load = 1'b1;
                    in_step  = 1'b1;
                    wr_en    = 1'b1;
                    state_d  = last_in ? upsample_pkg::FETCH : upsample_pkg::LOAD;
                end
            end
            upsample_pkg::LOAD: begin
                in_ready = 1'b1;
                if (in_valid) begin
                    in_step = 1'b1;
                    wr_en   = 1'b1;
                    if (last_in) begin
                        state_d = upsample_pkg::FETCH;
                    end
                end
            end
            upsample_pkg::FETCH: begin
                rd_en   = 1'b1;
                state_d = upsample_pkg::BLEND;
            end
            upsample_pkg::BLEND: begin
                blend_en = 1'b1;
                state_d  = upsample_pkg::EMIT;
            end
            upsample_pkg::EMIT: begin
                out_valid = 1'b1;
                if (out_ready) begin
                    out_step = 1'b1;
                    state_d  = last_out ? upsample_pkg::IDLE : upsample_pkg::FETCH;
                end
            end
            default: begin
                state_d = upsample_pkg::IDLE;
            end
        endcase
    end

endmodule

// ==== design/raster_counter.sv ====
// ==================================================
// input and output raster counters
// maps each output position to its source pixel and weight fractions
// ==================================================
`timescale 1ns/1ps
`include "upsample_config.svh"

module raster_counter (
    input  logic                        clk,
    input  logic                        rst_n,
    input  upsample_pkg::upsample_cfg_t cfg,
    input  logic                        in_step,
    input  logic                        out_step,
    input  logic                        start,
    output upsample_pkg::fb_addr_t      wr_addr,
    output logic                        last_in,
    output logic                        last_out,
    output upsample_pkg::sample_pos_t   sample_pos
);

    upsample_pkg::fb_addr_t     in_count;
    upsample_pkg::out_coord_t   out_x;
    upsample_pkg::out_coord_t   out_y;
    upsample_pkg::out_coord_t   out_w;
    upsample_pkg::out_coord_t   out_h;
    logic [`UPS_ADDR_W:0]       in_total;

    // (pos mod 2^s) * 256 / 2^s
    function automatic upsample_pkg::frac_t frac_of(upsample_pkg::out_coord_t pos,
                                                    upsample_pkg::scale_t s);
        upsample_pkg::out_coord_t low;
        low = pos & ((`UPS_OUT_W'(1) << s) - 1'b1);
        return upsample_pkg::frac_t'(low << (`UPS_FRAC_W - s));
    endfunction

    assign in_total = cfg.width * cfg.height;
    assign out_w    = upsample_pkg::out_coord_t'(cfg.width) << cfg.scale;
    assign out_h    = upsample_pkg::out_coord_t'(cfg.height) << cfg.scale;

    // the sof beat always lands at address 0
    assign wr_addr = start ? '0 : in_count;
    assign last_in = ({1'b0, wr_addr} == in_total - 1'b1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_count <= '0;
        end else if (in_step) begin
            in_count <= wr_addr + 1'b1;
        end
    end

    // ==================================================
    // output raster
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_x <= '0;
            out_y <= '0;
        end else if (start) begin
            out_x <= '0;
            out_y <= '0;
        end else if (out_step) begin
            if (out_x == out_w - 1'b1) begin
                out_x <= '0;
                out_y <= out_y + 1'b1;
            end else begin
                out_x <= out_x + 1'b1;
            end
        end
    end

    assign last_out = (out_x == out_w - 1'b1) && (out_y == out_h - 1'b1);

    assign sample_pos.src_x  = upsample_pkg::dim_t'(out_x >> cfg.scale);
    assign sample_pos.src_y  = upsample_pkg::dim_t'(out_y >> cfg.scale);
    assign sample_pos.frac_x = frac_of(out_x, cfg.scale);
    assign sample_pos.frac_y = frac_of(out_y, cfg.scale);
    assign sample_pos.first  = (out_x == '0) && (out_y == '0);
    assign sample_pos.eol    = (out_x == out_w - 1'b1);

    a_x_in_row: assert property (@(posedge clk) disable iff (!rst_n)
        out_step |-> out_x < out_w);

endmodule

// ==== design/frame_buffer.sv ====
// ==================================================
// whole-frame pixel store, written in raster order
// reads the 2x2 neighbourhood of a source position, clamped at the edges
// ==================================================
`timescale 1ns/1ps
`include "upsample_config.svh"

module frame_buffer (
    input  logic                        clk,
    input  logic                        wr_en,
    input  upsample_pkg::fb_addr_t      wr_addr,
    input  upsample_pkg::pixel_t        wr_pixel,
    input  logic                        rd_en,
    input  upsample_pkg::sample_pos_t   sample_pos,
    input  upsample_pkg::upsample_cfg_t cfg,
    output upsample_pkg::quad_t         quad
);

    upsample_pkg::pixel_t mem [0:`UPS_MAX_DIM*`UPS_MAX_DIM-1];
    upsample_pkg::dim_t   x_r;
    upsample_pkg::dim_t   y_b;
    logic [`UPS_ADDR_W:0] in_total;

    // frame is packed at the configured width, not the maximum
    function automatic upsample_pkg::fb_addr_t pix_addr(upsample_pkg::dim_t x,
                                                        upsample_pkg::dim_t y,
                                                        upsample_pkg::dim_t w);
        return upsample_pkg::fb_addr_t'(y) * w + x;
    endfunction

    // right column and bottom row repeat at the frame edge
    assign x_r = (sample_pos.src_x >= cfg.width - 1'b1) ? sample_pos.src_x
                                                        : sample_pos.src_x + 1'b1;
    assign y_b = (sample_pos.src_y >= cfg.height - 1'b1) ? sample_pos.src_y
                                                         : sample_pos.src_y + 1'b1;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_pixel;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            quad.tl <= mem[pix_addr(sample_pos.src_x, sample_pos.src_y, cfg.width)];
            quad.tr <= mem[pix_addr(x_r, sample_pos.src_y, cfg.width)];
            quad.bl <= mem[pix_addr(sample_pos.src_x, y_b, cfg.width)];
            quad.br <= mem[pix_addr(x_r, y_b, cfg.width)];
        end
    end

    assign in_total = cfg.width * cfg.height;

    // counter must never run past the configured frame
    a_wr_in_frame: assert property (@(posedge clk)
        wr_en |-> {1'b0, wr_addr} < in_total);

endmodule

// ==== design/bilinear_blend.sv ====
// ==================================================
// output pixel computation and the output beat register
// bilinear blend of the quad, or nearest pick of its top-left pixel
// ==================================================
`timescale 1ns/1ps
`include "upsample_config.svh"

module bilinear_blend (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      blend_en,
    input  logic                      bilinear,
    input  upsample_pkg::quad_t       quad,
    input  upsample_pkg::sample_pos_t sample_pos,
    output upsample_pkg::beat_t       beat
);

    logic [`UPS_FRAC_W:0]                   inv_x;
    logic [`UPS_FRAC_W:0]                   inv_y;
    logic [2*`UPS_FRAC_W:0]                 w_tl;
    logic [2*`UPS_FRAC_W:0]                 w_tr;
    logic [2*`UPS_FRAC_W:0]                 w_bl;
    logic [2*`UPS_FRAC_W:0]                 w_br;
    logic [`UPS_PIXEL_W+2*`UPS_FRAC_W+1:0]  acc;
    upsample_pkg::pixel_t                   blend_pix;

    // ==================================================
    // weights and weighted sum
    // ==================================================
    always_comb begin
        // 256 - f, distance weight toward the left or top pixel
        inv_x = (1 << `UPS_FRAC_W) - sample_pos.frac_x;
        inv_y = (1 << `UPS_FRAC_W) - sample_pos.frac_y;

        w_tl = inv_x * inv_y;
        w_tr = sample_pos.frac_x * inv_y;
        w_bl = inv_x * sample_pos.frac_y;
        w_br = sample_pos.frac_x * sample_pos.frac_y;

        // weights sum to 65536, so the result never exceeds 255
        acc = quad.tl * w_tl + quad.tr * w_tr + quad.bl * w_bl + quad.br * w_br;
        blend_pix = upsample_pkg::pixel_t'(acc >> (2 * `UPS_FRAC_W));
    end

    // ==================================================
    // beat register
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat <= '0;
        end else if (blend_en) begin
            beat.pixel <= bilinear ? blend_pix : quad.tl;
            beat.sof   <= sample_pos.first;
            beat.eol   <= sample_pos.eol;
        end
    end

endmodule

// ==== design/upsample_top.sv ====
// ==================================================
// feature-map upsampler top level, 1x to 8x
// takes one frame on the input stream, then streams the scaled frame out
// ==================================================
`timescale 1ns/1ps

module upsample_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  upsample_pkg::pixel_t        in_pixel,
    input  logic                        in_sof,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  upsample_pkg::upsample_cfg_t cfg,
    output upsample_pkg::beat_t         out_beat,
    output logic                        out_valid,
    input  logic                        out_ready
);

    upsample_pkg::upsample_cfg_t cfg_q;
    upsample_pkg::upsample_cfg_t cfg_cur;
    upsample_pkg::fb_addr_t      wr_addr;
    upsample_pkg::sample_pos_t   sample_pos;
    upsample_pkg::quad_t         quad;

    logic in_step;
    logic out_step;
    logic wr_en;
    logic rd_en;
    logic blend_en;
    logic cfg_load;
    logic last_in;
    logic last_out;

    // ==================================================
    // frame configuration
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_q <= '0;
        end else if (cfg_load) begin
            cfg_q <= cfg;
        end
    end

    // sof beat already needs the new sizes, e.g. for a 1x1 frame
    assign cfg_cur = cfg_load ? cfg : cfg_q;

    upsample_fsm u_fsm (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_sof    (in_sof),
        .last_in   (last_in),
        .last_out  (last_out),
        .out_ready (out_ready),
        .in_ready  (in_ready),
        .in_step   (in_step),
        .wr_en     (wr_en),
        .rd_en     (rd_en),
        .blend_en  (blend_en),
        .out_step  (out_step),
        .out_valid (out_valid),
        .cfg_load  (cfg_load)
    );

    raster_counter u_counter (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg        (cfg_cur),
        .in_step    (in_step),
        .out_step   (out_step),
        .start      (cfg_load),
        .wr_addr    (wr_addr),
        .last_in    (last_in),
        .last_out   (last_out),
        .sample_pos (sample_pos)
    );

    frame_buffer u_fb (
        .clk        (clk),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_pixel   (in_pixel),
        .rd_en      (rd_en),
        .sample_pos (sample_pos),
        .cfg        (cfg_cur),
        .quad       (quad)
    );

    bilinear_blend u_blend (
        .clk        (clk),
        .rst_n      (rst_n),
        .blend_en   (blend_en),
        .bilinear   (cfg_q.bilinear),
        .quad       (quad),
        .sample_pos (sample_pos),
        .beat       (out_beat)
    );

endmodule

// ==== bench/upsample_model.svh ====
// ==================================================
// reference model of the upsampler output stream
// holds the source frame and its configuration, included inside the testbench module
// ==================================================
`ifndef UPSAMPLE_MODEL_SVH
`define UPSAMPLE_MODEL_SVH

`include "upsample_config.svh"

int unsigned          model_w;
int unsigned          model_h;
int unsigned          model_scale;
bit                   model_bilinear;
upsample_pkg::pixel_t model_frame [0:`UPS_MAX_DIM*`UPS_MAX_DIM-1];

// configuration as it was on the sof beat
function automatic void model_start(upsample_pkg::upsample_cfg_t c);
    model_w        = c.width;
    model_h        = c.height;
    model_scale    = c.scale;
    model_bilinear = c.bilinear;
endfunction

function automatic int unsigned model_out_w();
    return model_w << model_scale;
endfunction

function automatic int unsigned model_out_h();
    return model_h << model_scale;
endfunction

function automatic int unsigned src_pixel(int unsigned x, int unsigned y);
    return model_frame[y * model_w + x];
endfunction

// share of the right or lower neighbour, in 1/256 steps
function automatic int unsigned frac_weight(int unsigned pos);
    int unsigned factor;
    factor = 1 << model_scale;
    return ((pos % factor) * 256) / factor;
endfunction

function automatic int unsigned expected_pixel(int unsigned ox, int unsigned oy);
    int unsigned sx;
    int unsigned sy;
    int unsigned xr;
    int unsigned yb;
    int unsigned fx;
    int unsigned fy;
    int unsigned acc;
    sx = ox >> model_scale;
    sy = oy >> model_scale;
    if (!model_bilinear) begin
        return src_pixel(sx, sy);
    end
    // last column and row repeat past the edge
    xr  = (sx + 1 < model_w) ? sx + 1 : model_w - 1;
    yb  = (sy + 1 < model_h) ? sy + 1 : model_h - 1;
    fx  = frac_weight(ox);
    fy  = frac_weight(oy);
    acc = src_pixel(sx, sy) * (256 - fx) * (256 - fy)
        + src_pixel(xr, sy) * fx * (256 - fy)
        + src_pixel(sx, yb) * (256 - fx) * fy
        + src_pixel(xr, yb) * fx * fy;
    return acc >> 16;
endfunction

`endif

// ==== bench/tb_upsample.sv ====
// ==================================================
// testbench for the feature-map upsampler
// random frames with stalls on both streams and every output beat checked
// ==================================================
`timescale 1ns/1ps

module tb_upsample;

    localparam int NUM_FRAMES = 12;

    logic                        clk;
    logic                        rst_n;
    upsample_pkg::pixel_t        in_pixel;
    logic                        in_sof;
    logic                        in_valid;
    logic                        in_ready;
    upsample_pkg::upsample_cfg_t cfg;
    upsample_pkg::beat_t         out_beat;
    logic                        out_valid;
    logic                        out_ready;

    upsample_pkg::upsample_cfg_t frame_cfg [NUM_FRAMES];
    int unsigned                 cycle_count;
    int unsigned                 cycle_limit;

    `include "upsample_model.svh"

    upsample_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_pixel  (in_pixel),
        .in_sof    (in_sof),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .cfg       (cfg),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "run stopped at the first error");
    endtask

    function automatic upsample_pkg::upsample_cfg_t random_cfg();
        upsample_pkg::upsample_cfg_t c;
        c.width    = upsample_pkg::dim_t'($urandom_range(1, 12));
        c.height   = upsample_pkg::dim_t'($urandom_range(1, 12));
        c.scale    = upsample_pkg::scale_t'($urandom_range(0, 3));
        c.bilinear = ($urandom_range(0, 1) == 1);
        return c;
    endfunction

    // ==================================================
    // frame list and run length
    // ==================================================
    task automatic pick_configs();
        int unsigned in_n;
        int unsigned out_n;
        for (int i = 0; i < NUM_FRAMES; i++) begin
            frame_cfg[i] = random_cfg();
        end
        // 1x in both modes, then a single pixel at 8x
        frame_cfg[0].scale    = 2'd0;
        frame_cfg[0].bilinear = 1'b0;
        frame_cfg[1].scale    = 2'd0;
        frame_cfg[1].bilinear = 1'b1;
        frame_cfg[2].width    = 6'd1;
        frame_cfg[2].height   = 6'd1;
        frame_cfg[2].scale    = 2'd3;
        frame_cfg[2].bilinear = 1'b1;
        cycle_limit = 1000;
        for (int i = 0; i < NUM_FRAMES; i++) begin
            // two extra for the discarded beats ahead of each frame
            in_n  = frame_cfg[i].width * frame_cfg[i].height + 2;
            out_n = (frame_cfg[i].width << frame_cfg[i].scale)
                  * (frame_cfg[i].height << frame_cfg[i].scale);
            cycle_limit += 4 * (in_n + 3 * out_n);
        end
    endtask

    // ==================================================
    // input stream
    // ==================================================
    task automatic send_beat(input upsample_pkg::pixel_t pix, input logic sof,
                             input upsample_pkg::upsample_cfg_t beat_cfg);
        bit taken;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            in_pixel = pix;
            in_sof   = sof;
            cfg      = beat_cfg;
            in_valid = ($urandom_range(0, 3) != 0);
            // in_ready depends on the state only, so it is settled here
            taken    = in_valid && in_ready;
        end
    endtask

    task automatic send_frame(input upsample_pkg::upsample_cfg_t fc);
        int unsigned junk;
        junk = $urandom_range(0, 2);
        repeat (junk) begin
            send_beat(upsample_pkg::pixel_t'($urandom_range(0, 255)), 1'b0, random_cfg());
        end
        // cfg keeps changing after the sof beat
        for (int i = 0; i < fc.width * fc.height; i++) begin
            send_beat(model_frame[i], (i == 0), (i == 0) ? fc : random_cfg());
        end
        @(negedge clk);
        in_valid = 1'b0;
        // a complete frame refuses further input
        assert (!in_ready)
        else abort_run($sformatf("Fail at %0t: in_ready still high after the last input beat",
                                 $time));
    endtask

    // ==================================================
    // output stream
    // ==================================================
    task automatic check_beat(input int unsigned ox, input int unsigned oy);
        int unsigned exp_pix;
        bit          exp_sof;
        bit          exp_eol;
        exp_pix = expected_pixel(ox, oy);
        exp_sof = (ox == 0) && (oy == 0);
        exp_eol = (ox == model_out_w() - 1);
        assert (out_beat.pixel == exp_pix)
        else abort_run($sformatf("Fail at %0t: pixel (%0d,%0d) is %0d, expected %0d",
                                 $time, ox, oy, out_beat.pixel, exp_pix));
        assert (out_beat.sof == exp_sof && out_beat.eol == exp_eol)
        else abort_run($sformatf("Fail at %0t: beat (%0d,%0d) has sof %0b eol %0b",
                                 $time, ox, oy, out_beat.sof, out_beat.eol));
    endtask

    task automatic receive_frame();
        int unsigned         ox;
        int unsigned         oy;
        bit                  stalled;
        upsample_pkg::beat_t held;
        ox      = 0;
        oy      = 0;
        stalled = 1'b0;
        held    = '0;
        while (oy < model_out_h()) begin
            @(negedge clk);
            if (stalled) begin
                assert (out_valid && out_beat == held)
                else abort_run($sformatf("Fail at %0t: stalled beat not held at (%0d,%0d)",
                                         $time, ox, oy));
            end
            out_ready = ($urandom_range(0, 3) != 0);
            stalled   = out_valid && !out_ready;
            held      = out_beat;
            if (out_valid && out_ready) begin
                check_beat(ox, oy);
                if (ox == model_out_w() - 1) begin
                    ox = 0;
                    oy++;
                end else begin
                    ox++;
                end
            end
        end
    endtask

    initial begin : watchdog
        wait (cycle_limit != 0);
        while (cycle_count <= cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        abort_run($sformatf("timeout: frames still running after %0d cycles", cycle_count));
    end

    initial begin
        void'($urandom(37));
        rst_n       = 1'b0;
        in_pixel    = '0;
        in_sof      = 1'b0;
        in_valid    = 1'b0;
        cfg         = '0;
        out_ready   = 1'b0;
        cycle_count = 0;
        pick_configs();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int f = 0; f < NUM_FRAMES; f++) begin
            model_start(frame_cfg[f]);
            for (int i = 0; i < frame_cfg[f].width * frame_cfg[f].height; i++) begin
                model_frame[i] = upsample_pkg::pixel_t'($urandom_range(0, 255));
            end
            fork
                send_frame(frame_cfg[f]);
                receive_frame();
            join
        end

        $display("** PASS **");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+design
+incdir+bench
design/upsample_pkg.sv
design/upsample_fsm.sv
design/raster_counter.sv
design/frame_buffer.sv
design/bilinear_blend.sv
design/upsample_top.sv
bench/tb_upsample.sv
